/* logic/he_eth_pkg.sv */
// Two ports only, packets are whole 64-bit words and lengths are limited to 2..64 words
`default_nettype none

package he_eth_pkg;

   localparam int ETH_DW    = 64;
   localparam int CSR_AW    = 8;
   localparam int CSR_DW    = 32;
   localparam int NUM_PORTS = 2;

   typedef logic [ETH_DW-1:0] eth_data_t;
   typedef logic [CSR_AW-1:0] csr_addr_t;
   typedef logic [CSR_DW-1:0] csr_data_t;
   typedef logic [0:0]        port_id_t;
   typedef logic [6:0]        pkt_len_t;
   typedef logic [15:0]       pkt_cnt_t;

   localparam pkt_len_t PKT_LEN_MIN = 7'd2;
   localparam pkt_len_t PKT_LEN_MAX = 7'd64;

   // Register offsets inside each 16-address port block
   localparam logic [3:0] REG_CTRL     = 4'd0;
   localparam logic [3:0] REG_NUM_PKTS = 4'd1;
   localparam logic [3:0] REG_PKT_LEN  = 4'd2;
   localparam logic [3:0] REG_TX_CNT   = 4'd3;
   localparam logic [3:0] REG_RX_GOOD  = 4'd4;
   localparam logic [3:0] REG_RX_BAD   = 4'd5;
   localparam logic [3:0] REG_STATUS   = 4'd6;

   typedef enum logic [1:0] {GEN_IDLE, GEN_HEAD, GEN_BODY} gen_state_t;
   typedef enum logic [1:0] {BR_IDLE, BR_CMD, BR_WAIT} bridge_state_t;

   // Word idx of a packet; idx 0 gives the header itself
   function automatic eth_data_t pattern_word(logic [3:0] port, pkt_len_t len,
                                              logic [7:0] idx, pkt_cnt_t seq);
      pattern_word        = '0;
      pattern_word[63:60] = port;
      pattern_word[31:24] = idx;
      pattern_word[22:16] = len;
      pattern_word[15:0]  = seq;
   endfunction

endpackage

`default_nettype wire

/* logic/eth_csr_bridge.sv */
// One host access at a time; ack rises four clock edges after the edge that launches the strobe
`default_nettype none
`timescale 1ns/1ps

module eth_csr_bridge (
   input  wire logic                  clk,
   input  wire logic                  softreset,
   input  wire he_eth_pkg::csr_addr_t i_host_addr,
   input  wire he_eth_pkg::csr_data_t i_host_wdata,
   input  wire logic                  i_host_rd,
   input  wire logic                  i_host_wr,
   input  wire he_eth_pkg::csr_data_t i_csr_rdata,
   input  wire logic                  i_csr_waitreq,
   output he_eth_pkg::csr_addr_t      o_csr_addr,
   output logic                       o_csr_rd,
   output logic                       o_csr_wr,
   output he_eth_pkg::csr_data_t      o_csr_wdata,
   output logic                       o_host_ack,
   output he_eth_pkg::csr_data_t      o_host_rdata
);

   he_eth_pkg::bridge_state_t state;
   logic                      wait_q;
   logic                      req;
   logic                      done;

   assign req  = (state == he_eth_pkg::BR_IDLE) && (i_host_rd || i_host_wr);
   assign done = (state == he_eth_pkg::BR_WAIT) && !wait_q;

   // Waitrequest is only seen one cycle late
   always_ff @(posedge clk) begin
      if (softreset) begin
         wait_q <= 1'b0;
      end else begin
         wait_q <= i_csr_waitreq;
      end
   end

   always_ff @(posedge clk) begin
      if (softreset) begin
         state      <= he_eth_pkg::BR_IDLE;
         o_csr_rd   <= 1'b0;
         o_csr_wr   <= 1'b0;
         o_host_ack <= 1'b0;
      end else begin
         o_host_ack <= 1'b0;
         case (state)
            he_eth_pkg::BR_IDLE: begin
               if (req) begin
                  o_csr_rd <= i_host_rd;
                  o_csr_wr <= i_host_wr;
                  state    <= he_eth_pkg::BR_CMD;
               end
            end
            // Delayed waitrequest still belongs to the idle bus here
            he_eth_pkg::BR_CMD: state <= he_eth_pkg::BR_WAIT;
            he_eth_pkg::BR_WAIT: begin
               if (done) begin
                  o_csr_rd   <= 1'b0;
                  o_csr_wr   <= 1'b0;
                  o_host_ack <= 1'b1;
                  state      <= he_eth_pkg::BR_IDLE;
               end
            end
            default: state <= he_eth_pkg::BR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (req) begin
         o_csr_addr  <= i_host_addr;
         o_csr_wdata <= i_host_wdata;
      end
      if (done) begin
         o_host_rdata <= i_csr_rdata;
      end
   end

endmodule

`default_nettype wire

/* logic/eth_traffic_csr.sv */
// Each access takes two cycles and stays complete until the master drops its command
`default_nettype none
`timescale 1ns/1ps

module eth_traffic_csr (
   input  wire logic                          clk,
   input  wire logic                          softreset,
   input  wire he_eth_pkg::csr_addr_t         i_csr_addr,
   input  wire logic                          i_csr_rd,
   input  wire logic                          i_csr_wr,
   input  wire he_eth_pkg::csr_data_t         i_csr_wdata,
   input  wire logic [he_eth_pkg::NUM_PORTS-1:0] i_gen_busy,
   input  wire logic [he_eth_pkg::NUM_PORTS-1:0] i_pkt_sent,
   input  wire logic                          i_rx_good,
   input  wire logic                          i_rx_bad,
   input  wire he_eth_pkg::port_id_t          i_rx_port,
   output he_eth_pkg::csr_data_t              o_csr_rdata,
   output logic                               o_csr_waitreq,
   output logic [he_eth_pkg::NUM_PORTS-1:0]   o_start,
   output he_eth_pkg::pkt_cnt_t               o_num_pkts [he_eth_pkg::NUM_PORTS],
   output he_eth_pkg::pkt_len_t               o_pkt_len [he_eth_pkg::NUM_PORTS]
);

   logic                                cmd;
   logic                                acc_q;
   logic                                done_q;
   logic                                do_write;
   logic                                port_ok;
   logic [3:0]                          offset;
   he_eth_pkg::port_id_t                port;
   he_eth_pkg::csr_data_t               rd_mux;
   logic [he_eth_pkg::NUM_PORTS-1:0]    start_wr;
   he_eth_pkg::pkt_cnt_t                tx_cnt [he_eth_pkg::NUM_PORTS];
   he_eth_pkg::pkt_cnt_t                good_cnt [he_eth_pkg::NUM_PORTS];
   he_eth_pkg::pkt_cnt_t                bad_cnt [he_eth_pkg::NUM_PORTS];

   function automatic he_eth_pkg::pkt_cnt_t sat_inc(he_eth_pkg::pkt_cnt_t v);
      sat_inc = (v == '1) ? v : v + 1'b1;
   endfunction

   function automatic he_eth_pkg::pkt_len_t clamp_len(he_eth_pkg::csr_data_t v);
      if (v < he_eth_pkg::PKT_LEN_MIN) begin
         clamp_len = he_eth_pkg::PKT_LEN_MIN;
      end else if (v > he_eth_pkg::PKT_LEN_MAX) begin
         clamp_len = he_eth_pkg::PKT_LEN_MAX;
      end else begin
         clamp_len = v[6:0];
      end
   endfunction

   assign cmd           = i_csr_rd || i_csr_wr;
   assign o_csr_waitreq = cmd && !acc_q && !done_q;
   assign port_ok       = i_csr_addr[7:4] < he_eth_pkg::NUM_PORTS;
   assign port          = i_csr_addr[4];
   assign offset        = i_csr_addr[3:0];
   // Writes take effect at the end of the second access cycle
   assign do_write      = acc_q && i_csr_wr && port_ok;

   always_comb begin
      for (int p = 0; p < he_eth_pkg::NUM_PORTS; p++) begin
         start_wr[p] = do_write && (port == p) && (offset == he_eth_pkg::REG_CTRL) &&
                       i_csr_wdata[0];
      end
   end

   always_comb begin
      rd_mux = '0;
      if (port_ok) begin
         case (offset)
            he_eth_pkg::REG_NUM_PKTS: rd_mux = {16'd0, o_num_pkts[port]};
            he_eth_pkg::REG_PKT_LEN:  rd_mux = {25'd0, o_pkt_len[port]};
            he_eth_pkg::REG_TX_CNT:   rd_mux = {16'd0, tx_cnt[port]};
            he_eth_pkg::REG_RX_GOOD:  rd_mux = {16'd0, good_cnt[port]};
            he_eth_pkg::REG_RX_BAD:   rd_mux = {16'd0, bad_cnt[port]};
            he_eth_pkg::REG_STATUS:   rd_mux = {31'd0, i_gen_busy[port]};
            default:                  rd_mux = '0;
         endcase
      end
   end

   // Access phases: waitrequest cycle, data cycle, then hold until command drops
   always_ff @(posedge clk) begin
      if (softreset) begin
         acc_q  <= 1'b0;
         done_q <= 1'b0;
      end else if (acc_q) begin
         acc_q  <= 1'b0;
         done_q <= 1'b1;
      end else if (done_q) begin
         done_q <= cmd;
      end else begin
         acc_q  <= cmd;
      end
   end

   always_ff @(posedge clk) begin
      if (o_csr_waitreq) begin
         o_csr_rdata <= rd_mux;
      end
   end

   always_ff @(posedge clk) begin
      if (softreset) begin
         o_start <= '0;
         for (int p = 0; p < he_eth_pkg::NUM_PORTS; p++) begin
            o_num_pkts[p] <= '0;
            o_pkt_len[p]  <= he_eth_pkg::PKT_LEN_MIN;
            tx_cnt[p]     <= '0;
            good_cnt[p]   <= '0;
            bad_cnt[p]    <= '0;
         end
      end else begin
         o_start <= start_wr;
         for (int p = 0; p < he_eth_pkg::NUM_PORTS; p++) begin
            if (do_write && (port == p) && (offset == he_eth_pkg::REG_NUM_PKTS)) begin
               o_num_pkts[p] <= i_csr_wdata[15:0];
            end
            if (do_write && (port == p) && (offset == he_eth_pkg::REG_PKT_LEN)) begin
               o_pkt_len[p] <= clamp_len(i_csr_wdata);
            end
            // A start clears the statistics of its own port
            if (start_wr[p]) begin
               tx_cnt[p]   <= '0;
               good_cnt[p] <= '0;
               bad_cnt[p]  <= '0;
            end else begin
               if (i_pkt_sent[p]) begin
                  tx_cnt[p] <= sat_inc(tx_cnt[p]);
               end
               if (i_rx_good && (i_rx_port == p)) begin
                  good_cnt[p] <= sat_inc(good_cnt[p]);
               end
               if (i_rx_bad && (i_rx_port == p)) begin
                  bad_cnt[p] <= sat_inc(bad_cnt[p]);
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

/* logic/eth_pkt_gen.sv */
// A start while busy is ignored; the length is assumed already clamped to at least 2
`default_nettype none
`timescale 1ns/1ps

module eth_pkt_gen #(
   parameter int PORT_ID = 0
) (
   input  wire logic                 clk,
   input  wire logic                 softreset,
   input  wire logic                 i_start,
   input  wire he_eth_pkg::pkt_cnt_t i_num_pkts,
   input  wire he_eth_pkg::pkt_len_t i_pkt_len,
   input  wire logic                 i_ready,
   output logic                      o_valid,
   output he_eth_pkg::eth_data_t     o_data,
   output logic                      o_last,
   output logic                      o_busy,
   output logic                      o_pkt_sent
);

   he_eth_pkg::gen_state_t state;
   he_eth_pkg::pkt_len_t   word_cnt;
   he_eth_pkg::pkt_len_t   len_q;
   he_eth_pkg::pkt_cnt_t   num_q;
   he_eth_pkg::pkt_cnt_t   seq_q;
   logic                   xfer;

   // Output word comes from registered state only, so it holds under back-pressure
   assign o_valid    = (state != he_eth_pkg::GEN_IDLE);
   assign o_busy     = o_valid;
   assign o_data     = he_eth_pkg::pattern_word(4'(PORT_ID), len_q, {1'b0, word_cnt}, seq_q);
   assign o_last     = (word_cnt == len_q - 1'b1);
   assign xfer       = o_valid && i_ready;
   assign o_pkt_sent = xfer && o_last;

   always_ff @(posedge clk) begin
      if ((state == he_eth_pkg::GEN_IDLE) && i_start) begin
         len_q <= i_pkt_len;
         num_q <= i_num_pkts;
      end
   end

   always_ff @(posedge clk) begin
      if (softreset) begin
         state    <= he_eth_pkg::GEN_IDLE;
         word_cnt <= '0;
         seq_q    <= '0;
      end else begin
         case (state)
            he_eth_pkg::GEN_IDLE: begin
               if (i_start) begin
                  word_cnt <= '0;
                  seq_q    <= '0;
                  // Zero packets finishes without leaving idle
                  state    <= (i_num_pkts == '0) ? he_eth_pkg::GEN_IDLE : he_eth_pkg::GEN_HEAD;
               end
            end
            he_eth_pkg::GEN_HEAD: begin
               if (xfer) begin
                  word_cnt <= 7'd1;
                  state    <= he_eth_pkg::GEN_BODY;
               end
            end
            he_eth_pkg::GEN_BODY: begin
               if (xfer && o_last) begin
                  word_cnt <= '0;
                  seq_q    <= seq_q + 1'b1;
                  if (he_eth_pkg::pkt_cnt_t'(seq_q + 1'b1) == num_q) begin
                     state <= he_eth_pkg::GEN_IDLE;
                  end else begin
                     state <= he_eth_pkg::GEN_HEAD;
                  end
               end else if (xfer) begin
                  word_cnt <= word_cnt + 1'b1;
               end
            end
            default: state <= he_eth_pkg::GEN_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* logic/eth_tx_arbiter.sv */
// Two requesters; a requester must hold valid from its first word until its last transfer
`default_nettype none
`timescale 1ns/1ps

module eth_tx_arbiter (
   input  wire logic                             clk,
   input  wire logic                             softreset,
   input  wire logic [he_eth_pkg::NUM_PORTS-1:0] i_req_valid,
   input  wire he_eth_pkg::eth_data_t            i_req_data [he_eth_pkg::NUM_PORTS],
   input  wire logic [he_eth_pkg::NUM_PORTS-1:0] i_req_last,
   output logic [he_eth_pkg::NUM_PORTS-1:0]      o_req_ready,
   output logic                                  o_tx_tvalid,
   output he_eth_pkg::eth_data_t                 o_tx_tdata,
   output logic                                  o_tx_tlast,
   input  wire logic                             i_tx_tready
);

   he_eth_pkg::port_id_t grant_q;
   he_eth_pkg::port_id_t other;
   he_eth_pkg::port_id_t sel;
   logic                 lock_q;

   assign other = ~grant_q;
   // Priority port keeps the bus unless idle and the other one is waiting
   assign sel   = (lock_q || i_req_valid[grant_q] || !i_req_valid[other]) ? grant_q : other;

   assign o_tx_tvalid = i_req_valid[sel];
   assign o_tx_tdata  = i_req_data[sel];
   assign o_tx_tlast  = i_req_last[sel];

   always_comb begin
      for (int p = 0; p < he_eth_pkg::NUM_PORTS; p++) begin
         o_req_ready[p] = i_tx_tready && (sel == p);
      end
   end

   // Lock on any presented word, so a stalled header cannot be swapped out
   always_ff @(posedge clk) begin
      if (softreset) begin
         grant_q <= '0;
         lock_q  <= 1'b0;
      end else if (o_tx_tvalid) begin
         if (i_tx_tready && o_tx_tlast) begin
            lock_q  <= 1'b0;
            grant_q <= ~sel;
         end else begin
            lock_q  <= 1'b1;
            grant_q <= sel;
         end
      end
   end

endmodule

`default_nettype wire

/* logic/eth_pkt_mon.sv */
// Always accepts; a packet with an out-of-range port id is reported as bad on port 0
`default_nettype none
`timescale 1ns/1ps

module eth_pkt_mon (
   input  wire logic                  clk,
   input  wire logic                  softreset,
   input  wire logic                  i_rx_tvalid,
   input  wire he_eth_pkg::eth_data_t i_rx_tdata,
   input  wire logic                  i_rx_tlast,
   output logic                       o_good,
   output logic                       o_bad,
   output he_eth_pkg::port_id_t       o_port
);

   logic                 in_pkt;
   logic                 err_q;
   he_eth_pkg::pkt_len_t idx_q;
   logic [3:0]           hdr_port_q;
   he_eth_pkg::pkt_len_t hdr_len_q;
   he_eth_pkg::pkt_cnt_t hdr_seq_q;
   logic [3:0]           cur_port;
   he_eth_pkg::pkt_len_t cur_len;
   he_eth_pkg::pkt_len_t cur_idx;
   he_eth_pkg::pkt_cnt_t cur_seq;
   logic                 word_err;

   always_comb begin
      if (in_pkt) begin
         cur_port = hdr_port_q;
         cur_len  = hdr_len_q;
         cur_seq  = hdr_seq_q;
         cur_idx  = idx_q;
      end else begin
         // Header fields straight off the wire
         cur_port = i_rx_tdata[63:60];
         cur_len  = i_rx_tdata[22:16];
         cur_seq  = i_rx_tdata[15:0];
         cur_idx  = '0;
      end
      word_err = (i_rx_tdata != he_eth_pkg::pattern_word(cur_port, cur_len, {1'b0, cur_idx},
                                                         cur_seq)) ||
                 (i_rx_tlast != (cur_idx == cur_len - 1'b1)) ||
                 (cur_port >= he_eth_pkg::NUM_PORTS);
   end

   always_ff @(posedge clk) begin
      if (softreset) begin
         in_pkt <= 1'b0;
         err_q  <= 1'b0;
         idx_q  <= '0;
         o_good <= 1'b0;
         o_bad  <= 1'b0;
      end else begin
         o_good <= 1'b0;
         o_bad  <= 1'b0;
         if (i_rx_tvalid && i_rx_tlast) begin
            o_good <= !(err_q || word_err);
            o_bad  <= err_q || word_err;
            in_pkt <= 1'b0;
            err_q  <= 1'b0;
            idx_q  <= '0;
         end else if (i_rx_tvalid) begin
            in_pkt <= 1'b1;
            err_q  <= err_q || word_err;
            idx_q  <= cur_idx + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_rx_tvalid && !in_pkt) begin
         hdr_port_q <= cur_port;
         hdr_len_q  <= cur_len;
         hdr_seq_q  <= cur_seq;
      end
      if (i_rx_tvalid && i_rx_tlast) begin
         o_port <= (cur_port < he_eth_pkg::NUM_PORTS) ? he_eth_pkg::port_id_t'(cur_port) : '0;
      end
   end

endmodule

`default_nettype wire

/* logic/he_eth_top.sv */
// Single clock domain; the MAC is outside, so tx and rx streams are only joined externally
`default_nettype none
`timescale 1ns/1ps

module he_eth_top (
   input  wire logic                  clk,
   input  wire logic                  softreset,
   input  wire he_eth_pkg::csr_addr_t i_host_addr,
   input  wire he_eth_pkg::csr_data_t i_host_wdata,
   input  wire logic                  i_host_rd,
   input  wire logic                  i_host_wr,
   output logic                       o_host_ack,
   output he_eth_pkg::csr_data_t      o_host_rdata,
   input  wire logic                  i_tx_tready,
   output logic                       o_tx_tvalid,
   output he_eth_pkg::eth_data_t      o_tx_tdata,
   output logic                       o_tx_tlast,
   input  wire logic                  i_rx_tvalid,
   input  wire he_eth_pkg::eth_data_t i_rx_tdata,
   input  wire logic                  i_rx_tlast
);

   he_eth_pkg::csr_addr_t            csr_addr;
   logic                             csr_rd;
   logic                             csr_wr;
   he_eth_pkg::csr_data_t            csr_wdata;
   he_eth_pkg::csr_data_t            csr_rdata;
   logic                             csr_waitreq;
   logic [he_eth_pkg::NUM_PORTS-1:0] start;
   he_eth_pkg::pkt_cnt_t             num_pkts [he_eth_pkg::NUM_PORTS];
   he_eth_pkg::pkt_len_t             pkt_len [he_eth_pkg::NUM_PORTS];
   logic [he_eth_pkg::NUM_PORTS-1:0] gen_busy;
   logic [he_eth_pkg::NUM_PORTS-1:0] pkt_sent;
   logic [he_eth_pkg::NUM_PORTS-1:0] gen_valid;
   he_eth_pkg::eth_data_t            gen_data [he_eth_pkg::NUM_PORTS];
   logic [he_eth_pkg::NUM_PORTS-1:0] gen_last;
   logic [he_eth_pkg::NUM_PORTS-1:0] gen_ready;
   logic                             rx_good;
   logic                             rx_bad;
   he_eth_pkg::port_id_t             rx_port;

   eth_csr_bridge u_bridge (
      .clk(clk), .softreset(softreset),
      .i_host_addr(i_host_addr), .i_host_wdata(i_host_wdata),
      .i_host_rd(i_host_rd), .i_host_wr(i_host_wr),
      .i_csr_rdata(csr_rdata), .i_csr_waitreq(csr_waitreq),
      .o_csr_addr(csr_addr), .o_csr_rd(csr_rd), .o_csr_wr(csr_wr), .o_csr_wdata(csr_wdata),
      .o_host_ack(o_host_ack), .o_host_rdata(o_host_rdata)
   );

   eth_traffic_csr u_csr (
      .clk(clk), .softreset(softreset),
      .i_csr_addr(csr_addr), .i_csr_rd(csr_rd), .i_csr_wr(csr_wr), .i_csr_wdata(csr_wdata),
      .i_gen_busy(gen_busy), .i_pkt_sent(pkt_sent),
      .i_rx_good(rx_good), .i_rx_bad(rx_bad), .i_rx_port(rx_port),
      .o_csr_rdata(csr_rdata), .o_csr_waitreq(csr_waitreq),
      .o_start(start), .o_num_pkts(num_pkts), .o_pkt_len(pkt_len)
   );

   for (genvar p = 0; p < he_eth_pkg::NUM_PORTS; p++) begin : g_gen
      eth_pkt_gen #(.PORT_ID(p)) u_gen (
         .clk(clk), .softreset(softreset),
         .i_start(start[p]), .i_num_pkts(num_pkts[p]), .i_pkt_len(pkt_len[p]),
         .i_ready(gen_ready[p]),
         .o_valid(gen_valid[p]), .o_data(gen_data[p]), .o_last(gen_last[p]),
         .o_busy(gen_busy[p]), .o_pkt_sent(pkt_sent[p])
      );
   end

   eth_tx_arbiter u_arb (
      .clk(clk), .softreset(softreset),
      .i_req_valid(gen_valid), .i_req_data(gen_data), .i_req_last(gen_last),
      .o_req_ready(gen_ready),
      .o_tx_tvalid(o_tx_tvalid), .o_tx_tdata(o_tx_tdata), .o_tx_tlast(o_tx_tlast),
      .i_tx_tready(i_tx_tready)
   );

   eth_pkt_mon u_mon (
      .clk(clk), .softreset(softreset),
      .i_rx_tvalid(i_rx_tvalid), .i_rx_tdata(i_rx_tdata), .i_rx_tlast(i_rx_tlast),
      .o_good(rx_good), .o_bad(rx_bad), .o_port(rx_port)
   );

endmodule

`default_nettype wire

/* dv/tb_clkgen.sv */
// Free-running clock that starts low; the period must be an even number of ns
`default_nettype none
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int PERIOD_NS = 40
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) o_clk = ~o_clk;
      end
   end

endmodule

`default_nettype wire

/* dv/he_eth_tb.sv */
// Transmit is looped back to receive in the testbench; only one host access is in flight at a time
`default_nettype none
`timescale 1ns/1ps

module he_eth_tb;

   localparam int          WATCHDOG_CYCLES = 20000;
   localparam int          MAX_POLLS       = 1000;
   localparam logic [31:0] SEED            = 32'h75b4370e;
   // Header carries only the port id, length and sequence number
   localparam logic [63:0] HDR_MASK        = 64'hf000_0000_007f_ffff;

   logic                  clk;
   logic                  softreset;
   he_eth_pkg::csr_addr_t host_addr;
   he_eth_pkg::csr_data_t host_wdata;
   logic                  host_rd;
   logic                  host_wr;
   logic                  host_ack;
   he_eth_pkg::csr_data_t host_rdata;
   logic                  tx_tready;
   logic                  tx_tvalid;
   he_eth_pkg::eth_data_t tx_tdata;
   logic                  tx_tlast;
   logic                  rx_tvalid;
   he_eth_pkg::eth_data_t rx_tdata;
   logic                  rx_tlast;

   // Stream model state shared between the checker and the main sequence
   logic [31:0]           rnd_state;
   logic                  bp_en = 1'b0;
   logic                  inject_armed = 1'b0;
   logic                  inject_port = 1'b0;
   logic [6:0]            cfg_len [2];
   logic [15:0]           exp_seq [2];
   logic [7:0]            tx_idx;
   logic [63:0]           tx_hdr;
   logic                  lb_valid;
   logic [63:0]           lb_data;
   logic                  lb_last;

   tb_clkgen #(.PERIOD_NS(40)) u_clkgen (.o_clk(clk));

   he_eth_top UUT (
      .clk(clk), .softreset(softreset),
      .i_host_addr(host_addr), .i_host_wdata(host_wdata),
      .i_host_rd(host_rd), .i_host_wr(host_wr),
      .o_host_ack(host_ack), .o_host_rdata(host_rdata),
      .i_tx_tready(tx_tready),
      .o_tx_tvalid(tx_tvalid), .o_tx_tdata(tx_tdata), .o_tx_tlast(tx_tlast),
      .i_rx_tvalid(rx_tvalid), .i_rx_tdata(rx_tdata), .i_rx_tlast(rx_tlast)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] v;
      v = s;
      v = v ^ (v << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   function automatic he_eth_pkg::csr_addr_t reg_addr(input int port, input logic [3:0] offset);
      reg_addr = {port[3:0], offset};
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic report_mismatch(input string msg);
      abort_run($sformatf("mismatch at %0t: %s", $time, msg));
   endtask

   // One strobe, then wait for the acknowledge
   task automatic host_access(input logic wr, input he_eth_pkg::csr_addr_t addr,
                              input he_eth_pkg::csr_data_t wdata,
                              output he_eth_pkg::csr_data_t rdata);
      int waited;
      waited = 0;
      @(posedge clk);
      #2;
      host_addr  = addr;
      host_wdata = wdata;
      host_rd    = !wr;
      host_wr    = wr;
      @(posedge clk);
      #2;
      host_rd = 1'b0;
      host_wr = 1'b0;
      @(negedge clk);
      while (!host_ack && waited < 8) begin
         @(negedge clk);
         waited++;
      end
      if (!host_ack) begin
         abort_run($sformatf("Host access to address %0h was never acknowledged", addr));
      end else begin
         rdata = host_rdata;
      end
   endtask

   task automatic write_reg(input int port, input logic [3:0] offset,
                            input he_eth_pkg::csr_data_t value);
      he_eth_pkg::csr_data_t unused;
      host_access(1'b1, reg_addr(port, offset), value, unused);
   endtask

   task automatic check_reg(input int port, input logic [3:0] offset,
                            input he_eth_pkg::csr_data_t expected, input string what);
      he_eth_pkg::csr_data_t got;
      host_access(1'b0, reg_addr(port, offset), '0, got);
      assert (got == expected)
         else report_mismatch($sformatf("%s read %0d, expected %0d", what, got, expected));
   endtask

   task automatic start_port(input int port, input int num, input int len);
      write_reg(port, he_eth_pkg::REG_NUM_PKTS, num);
      write_reg(port, he_eth_pkg::REG_PKT_LEN, len);
      cfg_len[port] = 7'(len);
      exp_seq[port] = '0;
      write_reg(port, he_eth_pkg::REG_CTRL, 32'd1);
   endtask

   task automatic wait_idle(input int port);
      he_eth_pkg::csr_data_t st;
      int polls;
      polls = 0;
      host_access(1'b0, reg_addr(port, he_eth_pkg::REG_STATUS), '0, st);
      while (st[0] && polls < MAX_POLLS) begin
         host_access(1'b0, reg_addr(port, he_eth_pkg::REG_STATUS), '0, st);
         polls++;
      end
      if (st[0]) begin
         abort_run($sformatf("Port %0d still busy after %0d status polls", port, polls));
      end
   endtask

   task automatic check_counts(input int port, input int sent, input int good, input int bad);
      check_reg(port, he_eth_pkg::REG_TX_CNT, sent, $sformatf("port %0d tx count", port));
      check_reg(port, he_eth_pkg::REG_RX_GOOD, good, $sformatf("port %0d rx good", port));
      check_reg(port, he_eth_pkg::REG_RX_BAD, bad, $sformatf("port %0d rx bad", port));
   endtask

   // Stalled word must stay presented and unchanged
   hold_under_stall: assert property (@(negedge clk) disable iff (softreset)
      $past(tx_tvalid && !tx_tready) |->
         (tx_tvalid && (tx_tdata == $past(tx_tdata)) && (tx_tlast == $past(tx_tlast))))
      else report_mismatch("transmit word changed or dropped while stalled");

   ack_latency: assert property (@(negedge clk) disable iff (softreset)
      host_ack == $past(host_rd || host_wr, 4))
      else report_mismatch("host acknowledge not exactly 4 cycles after the strobe");

   // Pattern check on every presented word, loopback capture and error injection
   always @(negedge clk) begin : tx_watch
      logic [63:0] expected;
      logic [3:0]  pid;
      lb_valid = 1'b0;
      if (softreset) begin
         tx_idx = '0;
      end else if (tx_tvalid) begin
         if (tx_idx == 0) begin
            pid = tx_tdata[63:60];
            assert ((tx_tdata & ~HDR_MASK) == 64'd0)
               else report_mismatch($sformatf("header %h has stray bits", tx_tdata));
            assert (pid < he_eth_pkg::NUM_PORTS)
               else report_mismatch($sformatf("header port id %0d out of range", pid));
            assert (tx_tdata[22:16] == cfg_len[pid[0]])
               else report_mismatch($sformatf("header length %0d on port %0d",
                                              tx_tdata[22:16], pid));
            assert (tx_tdata[15:0] == exp_seq[pid[0]])
               else report_mismatch($sformatf("sequence %0d on port %0d, expected %0d",
                                              tx_tdata[15:0], pid, exp_seq[pid[0]]));
            assert (!tx_tlast) else report_mismatch("last set on a header word");
         end else begin
            expected = tx_hdr | ({56'd0, tx_idx} << 24);
            assert (tx_tdata == expected)
               else report_mismatch($sformatf("word %0d is %h, expected %h",
                                              tx_idx, tx_tdata, expected));
            assert (tx_tlast == (tx_idx == {1'b0, tx_hdr[22:16]} - 8'd1))
               else report_mismatch($sformatf("last wrong at word %0d", tx_idx));
         end
         if (tx_tready) begin
            lb_valid = 1'b1;
            lb_data  = tx_tdata;
            lb_last  = tx_tlast;
            if (inject_armed && tx_idx != 0 && tx_hdr[60] == inject_port) begin
               lb_data[40]  = ~lb_data[40];
               inject_armed = 1'b0;
            end
            if (tx_idx == 0) begin
               tx_hdr = tx_tdata;
            end
            if (tx_tlast) begin
               tx_idx = '0;
               exp_seq[tx_hdr[60]] = exp_seq[tx_hdr[60]] + 16'd1;
            end else begin
               tx_idx = tx_idx + 8'd1;
            end
         end
      end
   end

   // Ready pattern and the registered loopback into the receive port
   initial begin : stream_drive
      rnd_state = SEED;
      tx_tready = 1'b0;
      rx_tvalid = 1'b0;
      rx_tdata  = '0;
      rx_tlast  = 1'b0;
      forever begin
         @(posedge clk);
         #2;
         rnd_state = xorshift32(rnd_state);
         tx_tready = bp_en ? (rnd_state[1:0] != 2'b00) : 1'b1;
         rx_tvalid = lb_valid;
         rx_tdata  = lb_data;
         rx_tlast  = lb_last;
      end
   end

   // Longest test needs a few thousand cycles at most
   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      abort_run($sformatf("Watchdog expired after %0d cycles, the run did not finish",
                          WATCHDOG_CYCLES));
   end

   initial begin : main_seq
      softreset  = 1'b1;
      host_addr  = '0;
      host_wdata = '0;
      host_rd    = 1'b0;
      host_wr    = 1'b0;
      lb_valid   = 1'b0;
      lb_data    = '0;
      lb_last    = 1'b0;
      cfg_len[0] = 7'd2;
      cfg_len[1] = 7'd2;
      exp_seq[0] = '0;
      exp_seq[1] = '0;
      repeat (5) @(posedge clk);
      #2;
      softreset = 1'b0;

      // Quiet state after reset
      check_reg(0, he_eth_pkg::REG_STATUS, 0, "port 0 status after reset");
      check_reg(1, he_eth_pkg::REG_TX_CNT, 0, "port 1 tx count after reset");

      // Register round trip and unused addresses
      write_reg(0, he_eth_pkg::REG_NUM_PKTS, 32'h0000_5a3c);
      check_reg(0, he_eth_pkg::REG_NUM_PKTS, 32'h5a3c, "num_pkts readback");
      check_reg(0, 4'd9, 0, "unused offset");
      check_reg(2, he_eth_pkg::REG_NUM_PKTS, 0, "port block out of range");

      // Length clamps to 2..64
      write_reg(0, he_eth_pkg::REG_PKT_LEN, 32'd100);
      check_reg(0, he_eth_pkg::REG_PKT_LEN, 64, "length clamped high");
      write_reg(0, he_eth_pkg::REG_PKT_LEN, 32'd1);
      check_reg(0, he_eth_pkg::REG_PKT_LEN, 2, "length clamped low");

      // Single port at full rate
      start_port(0, 5, 8);
      wait_idle(0);
      check_counts(0, 5, 5, 0);

      // Both ports sharing the stream under random back-pressure
      bp_en = 1'b1;
      start_port(0, 6, 5);
      start_port(1, 4, 11);
      wait_idle(0);
      wait_idle(1);
      check_counts(0, 6, 6, 0);
      check_counts(1, 4, 4, 0);

      // One corrupted body word on port 1
      inject_port  = 1'b1;
      inject_armed = 1'b1;
      start_port(1, 4, 3);
      wait_idle(1);
      if (inject_armed) begin
         abort_run("Error injection never found a body word of port 1 to corrupt");
      end
      check_counts(1, 4, 3, 1);

      // Zero packets finishes at once
      bp_en = 1'b0;
      start_port(0, 0, 4);
      check_reg(0, he_eth_pkg::REG_STATUS, 0, "busy after zero-count start");
      check_counts(0, 0, 0, 0);

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
logic/he_eth_pkg.sv
logic/eth_csr_bridge.sv
logic/eth_traffic_csr.sv
logic/eth_pkt_gen.sv
logic/eth_tx_arbiter.sv
logic/eth_pkt_mon.sv
logic/he_eth_top.sv
dv/tb_clkgen.sv
dv/he_eth_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f filelist.f --top-module he_eth_tb -o he_eth_sim

# The simulator exits non-zero on $fatal, so the log decides the result
./obj_dir/he_eth_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
   exit 1
fi
grep -q "TESTBENCH PASSED" sim.log
